/* Makefile */
# Verilator build and run for the vicii_raster testbench

VERILATOR ?= verilator
TOP       ?= tb_vic_core
FILELIST  ?= vicii_raster.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tb_vic_core.sv */
`timescale 1ns/1ps

module tb_vic_core;

   // one pal line and one frame in clk_dot4x clocks
   localparam int LINE_CLKS    = 2016;
   localparam int FRAME_CLKS   = 312 * LINE_CLKS;
   // run past the frame wrap into the first bad lines of frame 1
   localparam int END_CLKS     = FRAME_CLKS + 64 * LINE_CLKS;
   localparam int TIMEOUT_CLKS = 2 * FRAME_CLKS + 10000;
   // 25 bad lines in frame 0 and 2 in lines 48 to 63 of frame 1, 43 cycles each
   localparam int BA_LOW_CLKS  = 27 * 43 * 32;
   localparam logic [31:0] LFSR_SEED = 32'haa1b_3dfb;

   typedef struct packed {
      int   tick;
      logic phi;
      int   raster_x;
      int   line;
      int   line_d;
      logic badline;
      logic ba;
      logic aec;
   } exp_pos_t;

   logic                  clk_dot4x;
   logic                  rst;
   vic_pkg::reg_addr_t    adi;
   vic_pkg::reg_data_t    dbi;
   logic                  ce;
   logic                  rw;
   logic                  clk_phi;
   vic_pkg::raster_x_t    raster_x;
   vic_pkg::raster_line_t raster_line;
   vic_pkg::reg_data_t    dbo;
   logic                  irq;
   logic                  ba;
   logic                  aec;
   logic                  vic_write_db;
   logic                  vic_write_ab;
   logic                  ls245_data_dir;

   // clocks since reset release, also the timeout counter
   int                    clk_count;
   int                    ba_low_count;
   logic [31:0]           lfsr_state;
   // register values the stimulus writes
   logic                  set_den;
   int                    set_yscroll;
   int                    cmp_line;
   vic_pkg::reg_addr_t    adi_prev;
   exp_pos_t              exp_now;

   vic_core dut0 (
      .clk_dot4x      (clk_dot4x),
      .rst            (rst),
      .adi            (adi),
      .dbi            (dbi),
      .ce             (ce),
      .rw             (rw),
      .clk_phi        (clk_phi),
      .raster_x       (raster_x),
      .raster_line    (raster_line),
      .dbo            (dbo),
      .irq            (irq),
      .ba             (ba),
      .aec            (aec),
      .vic_write_db   (vic_write_db),
      .vic_write_ab   (vic_write_ab),
      .ls245_data_dir (ls245_data_dir)
   );

   initial begin
      clk_dot4x = 1'b0;
      forever #10 clk_dot4x = ~clk_dot4x;
   end

   // galois lfsr, right shift
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = (s >> 1) ^ (s[0] ? 32'hD000_0001 : 32'h0);
   endfunction

   // one lfsr step per bit taken
   task automatic draw_bits(input int n, output int val);
      int i;
      val = 0;
      for (i = 0; i < n; i++) begin
         val = (val << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_val(input string name, input int got, input int expected);
      if (got !== expected) begin
         $display("ERR %0t %s got %0h expected %0h", $time, name, got, expected);
         fail_run("value mismatch");
      end
   endtask

   // one dot every 4 clocks, 504 dots a line, 312 lines a frame
   function automatic int line_after(input int n);
      line_after = (n / 4 / 504) % 312;
   endfunction

   // delayed line latched on the edge leaving tick 16
   function automatic int delayed_line_after(input int n);
      if (n < 17) begin
         delayed_line_after = 0;
      end else begin
         delayed_line_after = line_after(n - ((n - 17) % 32) - 1);
      end
   endfunction

   function automatic logic badline_after(input int n);
      int ld;
      ld = delayed_line_after(n);
      badline_after = set_den && ld >= 48 && ld < 248 && (ld % 8) == set_yscroll;
   endfunction

   // ba low for cycles 12 to 54 of a bad line
   function automatic logic ba_after(input int n);
      int cycle;
      cycle = ((n / 4) % 504) / 8;
      ba_after = !(badline_after(n) && cycle >= 12 && cycle < 55);
   endfunction

   // cascade shifts on edges leaving tick 31, ba3 is the or of the last three samples
   function automatic logic ba3_after(input int n);
      int shift;
      int i;
      shift = n - (n % 32);
      ba3_after = 1'b0;
      for (i = 0; i < 3; i++) begin
         if (shift - 32 * i < 32) begin
            ba3_after = 1'b1;
         end else begin
            ba3_after = ba3_after | ba_after(shift - 32 * i - 1);
         end
      end
   endfunction

   function automatic exp_pos_t ref_pos(input int n);
      exp_pos_t r;
      int       p;
      logic     phi_p;
      r.tick     = n % 32;
      r.phi      = r.tick >= 16;
      r.raster_x = (n / 4) % 504;
      r.line     = line_after(n);
      r.line_d   = delayed_line_after(n);
      r.badline  = badline_after(n);
      r.ba       = ba_after(n);
      // aec is registered one clock behind phi
      if (n == 0) begin
         r.aec = 1'b0;
      end else begin
         p     = n - 1;
         phi_p = (p % 32) >= 16;
         r.aec = ba_after(p) ? phi_p : (ba3_after(p) & phi_p);
      end
      ref_pos = r;
   endfunction

   always @(posedge clk_dot4x) begin
      if (!rst) begin
         clk_count <= clk_count + 1;
         if (clk_count >= TIMEOUT_CLKS) begin
            fail_run("timeout, the test sequence did not reach its end");
         end
      end
   end

   // compare outputs mid cycle, inputs change 2 ns after the rising edge
   always @(negedge clk_dot4x) begin
      if (!rst) begin
         exp_now = ref_pos(clk_count);
         check_val("clk_phi", int'(clk_phi), int'(exp_now.phi));
         check_val("raster_x", int'(raster_x), exp_now.raster_x);
         check_val("raster_line", int'(raster_line), exp_now.line);
         check_val("ba", int'(ba), int'(exp_now.ba));
         check_val("aec", int'(aec), int'(exp_now.aec));
         check_val("vic_write_db", int'(vic_write_db), int'(exp_now.aec & rw & !ce));
         check_val("vic_write_ab", int'(vic_write_ab), int'(!exp_now.aec));
         check_val("ls245_data_dir", int'(ls245_data_dir),
                   int'(!(exp_now.aec & rw & !ce)));
         // idle address is the raster register
         if (clk_count > 0 && adi_prev == vic_pkg::REG_RASTER) begin
            check_val("dbo", int'(dbo), delayed_line_after(clk_count - 1) % 256);
         end
         if (!ba && clk_count < END_CLKS) begin
            ba_low_count++;
         end
      end
      adi_prev = adi;
   end

   // hold the write until the tick 28 edge finds aec high
   task automatic write_reg(input vic_pkg::reg_addr_t addr, input vic_pkg::reg_data_t data);
      @(posedge clk_dot4x);
      #2;
      adi = addr;
      dbi = data;
      ce  = 1'b0;
      rw  = 1'b0;
      @(negedge clk_dot4x);
      while (!((clk_count % 32) == 28 && aec)) @(negedge clk_dot4x);
      @(posedge clk_dot4x);
      #2;
      ce  = 1'b1;
      rw  = 1'b1;
      adi = vic_pkg::REG_RASTER;
   endtask

   task automatic read_reg(input vic_pkg::reg_addr_t addr, input int expected,
                           input string name);
      @(posedge clk_dot4x);
      #2;
      adi = addr;
      ce  = 1'b0;
      rw  = 1'b1;
      // dbo registers on the next edge
      @(posedge clk_dot4x);
      @(negedge clk_dot4x);
      check_val(name, int'(dbo), expected);
      @(posedge clk_dot4x);
      #2;
      ce  = 1'b1;
      adi = vic_pkg::REG_RASTER;
   endtask

   // acknowledge the raster irq, the clear pulse drops the latch one clock later
   task automatic ack_irq();
      write_reg(vic_pkg::REG_IRQ, 8'h01);
      @(negedge clk_dot4x);
      check_val("irq", int'(irq), 1);
      @(negedge clk_dot4x);
      check_val("irq", int'(irq), 0);
   endtask

   initial begin
      rst          = 1'b1;
      ce           = 1'b1;
      rw           = 1'b1;
      adi          = vic_pkg::REG_RASTER;
      dbi          = 8'h00;
      clk_count    = 0;
      ba_low_count = 0;
      lfsr_state   = LFSR_SEED;
      set_den      = 1'b1;
      draw_bits(3, set_yscroll);
      draw_bits(6, cmp_line);
      repeat (5) @(posedge clk_dot4x);
      #2;
      rst = 1'b0;
      // line 0 matches the reset compare value while erst is clear
      while (clk_count < 32) @(negedge clk_dot4x);
      check_val("irq", int'(irq), 0);
      read_reg(vic_pkg::REG_IRQ, 'h71, "dbo_irq");
      write_reg(vic_pkg::REG_CTRL1, 8'(16 + set_yscroll));
      write_reg(vic_pkg::REG_RASTER, 8'(cmp_line));
      read_reg(vic_pkg::REG_CTRL1, 16 + set_yscroll, "dbo_ctrl1");
      // enabling with the latch set raises irq on the next clock
      write_reg(vic_pkg::REG_IRQ_EN, 8'h01);
      @(negedge clk_dot4x);
      check_val("irq", int'(irq), 1);
      read_reg(vic_pkg::REG_IRQ_EN, 'hf1, "dbo_irq_en");
      read_reg(vic_pkg::REG_IRQ, 'hf1, "dbo_irq");
      ack_irq();
      read_reg(vic_pkg::REG_IRQ, 'h70, "dbo_irq");
      // raster irq on the compare line, set on the edge leaving tick 17
      @(negedge clk_dot4x);
      while (!irq) @(negedge clk_dot4x);
      check_val("irq_tick", clk_count % 32, 18);
      check_val("irq_line", delayed_line_after(clk_count), cmp_line);
      repeat (64) begin
         @(negedge clk_dot4x);
         check_val("irq", int'(irq), 1);
      end
      ack_irq();
      // no second irq while the delayed line still matches
      while (delayed_line_after(clk_count) == cmp_line) begin
         check_val("irq", int'(irq), 0);
         @(negedge clk_dot4x);
      end
      while (clk_count < END_CLKS) @(negedge clk_dot4x);
      @(posedge clk_dot4x);
      check_val("ba_low_clocks", ba_low_count, BA_LOW_CLKS);
      $display("Verification passed");
      $finish;
   end

endmodule

/* vic_bus_arbiter.sv */
`timescale 1ns/1ps

module vic_bus_arbiter (
   input  logic                 clk_dot4x,
   input  logic                 rst,
   input  vic_pkg::raster_pos_t pos,
   input  logic                 badline,
   input  logic                 ce,
   input  logic                 rw,
   output logic                 ba,
   output logic                 aec,
   output logic                 vic_write_db,
   output logic                 vic_write_ab,
   output logic                 ls245_data_dir
);

   // ba history over the last three phi high phases
   logic ba1;
   logic ba2;
   logic ba3;
   logic chars_window;

   // character fetch cycles, three ahead of the first c-access
   assign chars_window = (pos.cycle_num >= vic_pkg::BA_CHARS_FIRST_CYCLE) &&
                         (pos.cycle_num < vic_pkg::BA_CHARS_END_CYCLE);

   // ba is active low
   assign ba = !(badline && chars_window);

   // shift at the end of phi high so aec is withheld
   // on the third phi high after ba falls
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba1 <= 1'b1;
         ba2 <= 1'b1;
         ba3 <= 1'b1;
      end else if (pos.phi && pos.tick == vic_pkg::TICK_BA_SHIFT) begin
         ba1 <= ba;
         ba2 <= ba1 | ba;
         ba3 <= ba2 | ba;
      end
   end

   // aec low in phi low for vic, high in phi high for cpu
   // unless the cpu cycle has been taken
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         aec <= 1'b0;
      end else begin
         aec <= ba ? pos.phi : (ba3 & pos.phi);
      end
   end

   // drive the data bus only for a cpu read of a register
   assign vic_write_db = aec && rw && !ce;

   // aec low means we own the address bus
   assign vic_write_ab = !aec;

   // ls245 dir low lets the vic drive the bus
   assign ls245_data_dir = !vic_write_db;

endmodule

/* vic_core.sv */
`timescale 1ns/1ps

module vic_core (
   input  logic                  clk_dot4x,
   input  logic                  rst,
   input  vic_pkg::reg_addr_t    adi,
   input  vic_pkg::reg_data_t    dbi,
   input  logic                  ce,
   input  logic                  rw,
   output logic                  clk_phi,
   output vic_pkg::raster_x_t    raster_x,
   output vic_pkg::raster_line_t raster_line,
   output vic_pkg::reg_data_t    dbo,
   output logic                  irq,
   output logic                  ba,
   output logic                  aec,
   output logic                  vic_write_db,
   output logic                  vic_write_ab,
   output logic                  ls245_data_dir
);

   vic_pkg::raster_pos_t pos;
   vic_pkg::vic_ctrl_t   ctrl;
   logic                 irst;
   logic                 badline;

   // phase generator and raster counters
   vic_timing u_timing (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .pos       (pos),
      .clk_phi   (clk_phi)
   );

   // cpu registers and readback
   vic_reg_decode u_reg_decode (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .pos       (pos),
      .adi       (adi),
      .dbi       (dbi),
      .ce        (ce),
      .rw        (rw),
      .aec       (aec),
      .irst      (irst),
      .irq       (irq),
      .ctrl      (ctrl),
      .dbo       (dbo)
   );

   // bad line and raster irq latch
   vic_raster_irq u_raster_irq (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .pos       (pos),
      .ctrl      (ctrl),
      .badline   (badline),
      .irst      (irst)
   );

   // ba, aec and transceiver direction
   vic_bus_arbiter u_bus_arbiter (
      .clk_dot4x      (clk_dot4x),
      .rst            (rst),
      .pos            (pos),
      .badline        (badline),
      .ce             (ce),
      .rw             (rw),
      .ba             (ba),
      .aec            (aec),
      .vic_write_db   (vic_write_db),
      .vic_write_ab   (vic_write_ab),
      .ls245_data_dir (ls245_data_dir)
   );

   // latch is set even while disabled, so enabling raises irq at once
   assign irq         = irst & ctrl.erst;
   assign raster_x    = pos.raster_x;
   assign raster_line = pos.raster_line;

endmodule

/* vic_pkg.sv */
package vic_pkg;

   // widths that carry a meaning
   typedef logic [9:0] raster_x_t;
   typedef logic [8:0] raster_line_t;
   // phi cycle within a line, raster x divided by 8
   typedef logic [6:0] cycle_num_t;
   // position of clk_dot4x inside one phi period
   typedef logic [4:0] phase_tick_t;
   typedef logic [5:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;
   typedef logic [2:0] yscroll_t;

   // pal 6569 wrap points, 504 dots by 312 lines
   localparam raster_x_t    RASTER_X_MAX = 10'd503;
   localparam raster_line_t RASTER_Y_MAX = 9'd311;

   // phase ticks within one phi period of 32 clocks
   // phi is high on ticks 16 to 31
   localparam phase_tick_t TICK_PHI_HIGH   = 5'd16;
   // cpu write data is stable late in phi high
   localparam phase_tick_t TICK_REG_DAV    = 5'd28;
   localparam phase_tick_t TICK_LINE_LATCH = 5'd16;
   localparam phase_tick_t TICK_IRQ_CHECK  = 5'd17;
   // last tick of phi high, ba cascade moves here
   localparam phase_tick_t TICK_BA_SHIFT   = 5'd31;

   // bad line window, end is exclusive
   localparam raster_line_t BADLINE_FIRST = 9'd48;
   localparam raster_line_t BADLINE_END   = 9'd248;

   // cycles in which ba is held low for character fetches
   localparam cycle_num_t BA_CHARS_FIRST_CYCLE = 7'd12;
   localparam cycle_num_t BA_CHARS_END_CYCLE   = 7'd55;

   // register addresses, offsets from 0xd000
   localparam reg_addr_t REG_CTRL1  = 6'h11;
   localparam reg_addr_t REG_RASTER = 6'h12;
   localparam reg_addr_t REG_IRQ    = 6'h19;
   localparam reg_addr_t REG_IRQ_EN = 6'h1a;

   // unused interrupt register bits read back high
   localparam reg_data_t IRQ_UNUSED_BITS = 8'h70;

   // raster position and phase, one driver in vic_timing
   typedef struct packed {
      logic         phi;
      phase_tick_t  tick;
      logic         dot_strobe;
      raster_x_t    raster_x;
      cycle_num_t   cycle_num;
      raster_line_t raster_line;
      raster_line_t raster_line_d;
   } raster_pos_t;

   // control fields from the cpu register file
   typedef struct packed {
      logic         den;
      yscroll_t     yscroll;
      raster_line_t raster_cmp;
      logic         erst;
      logic         irst_clr;
   } vic_ctrl_t;

endpackage

/* vic_raster_irq.sv */
`timescale 1ns/1ps

module vic_raster_irq (
   input  logic                 clk_dot4x,
   input  logic                 rst,
   input  vic_pkg::raster_pos_t pos,
   input  vic_pkg::vic_ctrl_t   ctrl,
   output logic                 badline,
   output logic                 irst
);

   // yscroll as seen at the start of phi high
   vic_pkg::yscroll_t yscroll_d;
   // bad lines enabled for this frame
   logic              allow_bad_lines;
   // raster irq already raised on this line
   logic              irq_fired;
   logic              in_window;

   // latch yscroll one clock before the compare tick
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         yscroll_d <= '0;
      end else if (pos.tick == vic_pkg::TICK_LINE_LATCH) begin
         yscroll_d <= ctrl.yscroll;
      end
   end

   // den only counts on line 48, any cycle of it
   // window closes again on line 248
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_lines <= 1'b0;
      end else if (pos.tick == vic_pkg::TICK_LINE_LATCH) begin
         if (pos.raster_line == vic_pkg::BADLINE_FIRST && ctrl.den) begin
            allow_bad_lines <= 1'b1;
         end
         if (pos.raster_line == vic_pkg::BADLINE_END) begin
            allow_bad_lines <= 1'b0;
         end
      end
   end

   assign in_window = (pos.raster_line_d >= vic_pkg::BADLINE_FIRST) &&
                      (pos.raster_line_d < vic_pkg::BADLINE_END);

   // bad line when the low line bits match yscroll
   assign badline = allow_bad_lines && in_window &&
                    (pos.raster_line_d[2:0] == yscroll_d);

   // raster compare against the delayed line
   // raises irst once per line, the flag drops when the line moves on
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irst      <= 1'b0;
         irq_fired <= 1'b0;
      end else begin
         if (pos.tick == vic_pkg::TICK_IRQ_CHECK) begin
            if (pos.raster_line_d == ctrl.raster_cmp) begin
               if (!irq_fired) begin
                  irq_fired <= 1'b1;
                  irst      <= 1'b1;
               end
            end else begin
               irq_fired <= 1'b0;
            end
         end
         // cpu acknowledge wins over a new set
         if (ctrl.irst_clr) begin
            irst <= 1'b0;
         end
      end
   end

endmodule

/* vic_reg_decode.sv */
`timescale 1ns/1ps

module vic_reg_decode (
   input  logic                 clk_dot4x,
   input  logic                 rst,
   input  vic_pkg::raster_pos_t pos,
   input  vic_pkg::reg_addr_t   adi,
   input  vic_pkg::reg_data_t   dbi,
   input  logic                 ce,
   input  logic                 rw,
   input  logic                 aec,
   input  logic                 irst,
   input  logic                 irq,
   output vic_pkg::vic_ctrl_t   ctrl,
   output vic_pkg::reg_data_t   dbo
);

   // register fields
   logic                  den;
   vic_pkg::yscroll_t     yscroll;
   vic_pkg::raster_line_t raster_cmp;
   logic                  erst;
   logic                  irst_clr;

   // write strobe, one clock per phi high
   logic                  wr_en;

   // cpu owns the bus, chip selected, write cycle
   // data is sampled late in phi high where it has settled
   assign wr_en = pos.phi && aec && !ce && !rw &&
                  (pos.tick == vic_pkg::TICK_REG_DAV);

   // write side register file
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         den        <= 1'b0;
         yscroll    <= '0;
         raster_cmp <= '0;
         erst       <= 1'b0;
         irst_clr   <= 1'b0;
      end else begin
         // clear request lasts a single clock
         irst_clr <= 1'b0;
         if (wr_en) begin
            case (adi)
               vic_pkg::REG_CTRL1: begin
                  // bit 7 is the ninth compare bit
                  raster_cmp[8] <= dbi[7];
                  den           <= dbi[4];
                  yscroll       <= dbi[2:0];
               end
               vic_pkg::REG_RASTER: begin
                  raster_cmp[7:0] <= dbi;
               end
               vic_pkg::REG_IRQ: begin
                  // writing a 1 acknowledges the raster irq
                  irst_clr <= dbi[0];
               end
               vic_pkg::REG_IRQ_EN: begin
                  erst <= dbi[0];
               end
               default: begin
                  // other addresses have no register here
               end
            endcase
         end
      end
   end

   // readback mux, registered every clock
   always_ff @(posedge clk_dot4x) begin
      case (adi)
         vic_pkg::REG_CTRL1: begin
            // line bit 8 from the delayed copy
            dbo <= {pos.raster_line_d[8], 2'b00, den, 1'b0, yscroll};
         end
         vic_pkg::REG_RASTER: begin
            dbo <= pos.raster_line_d[7:0];
         end
         vic_pkg::REG_IRQ: begin
            dbo <= vic_pkg::IRQ_UNUSED_BITS | {irq, 6'b000000, irst};
         end
         vic_pkg::REG_IRQ_EN: begin
            // top bit always set, enable in bit 0
            dbo <= vic_pkg::IRQ_UNUSED_BITS | {1'b1, 6'b000000, erst};
         end
         default: begin
            dbo <= 8'hff;
         end
      endcase
   end

   // control bundle for the raster irq block
   always_comb begin
      ctrl.den        = den;
      ctrl.yscroll    = yscroll;
      ctrl.raster_cmp = raster_cmp;
      ctrl.erst       = erst;
      ctrl.irst_clr   = irst_clr;
   end

endmodule

/* vic_timing.sv */
`timescale 1ns/1ps

module vic_timing (
   input  logic                 clk_dot4x,
   input  logic                 rst,
   output vic_pkg::raster_pos_t pos,
   output logic                 clk_phi
);

   // rotating tick, 32 clk_dot4x per phi period
   vic_pkg::phase_tick_t  tick;
   vic_pkg::raster_x_t    raster_x;
   vic_pkg::raster_line_t raster_line;
   vic_pkg::raster_line_t raster_line_d;
   logic                  phi;
   logic                  dot_strobe;

   // tick counter, wraps on its own at 31
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         tick <= '0;
      end else begin
         tick <= tick + 5'd1;
      end
   end

   // phi low on ticks 0 to 15, high on 16 to 31
   assign phi = (tick >= vic_pkg::TICK_PHI_HIGH);

   // four clocks per dot, last one moves raster x
   assign dot_strobe = (tick[1:0] == 2'b11);

   // raster x and line counters with pal wrap
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x    <= '0;
         raster_line <= '0;
      end else if (dot_strobe) begin
         if (raster_x == vic_pkg::RASTER_X_MAX) begin
            raster_x <= '0;
            // end of line, step to next line or back to top
            if (raster_line == vic_pkg::RASTER_Y_MAX) begin
               raster_line <= '0;
            end else begin
               raster_line <= raster_line + 9'd1;
            end
         end else begin
            raster_x <= raster_x + 10'd1;
         end
      end
   end

   // delayed line, taken at the start of phi high
   // and held for the rest of the phi period
   // compare and readback both see this copy
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_line_d <= '0;
      end else if (tick == vic_pkg::TICK_LINE_LATCH) begin
         raster_line_d <= raster_line;
      end
   end

   // pack the position for the other blocks
   always_comb begin
      pos.phi           = phi;
      pos.tick          = tick;
      pos.dot_strobe    = dot_strobe;
      pos.raster_x      = raster_x;
      // each phi cycle spans 8 dots
      pos.cycle_num     = raster_x[9:3];
      pos.raster_line   = raster_line;
      pos.raster_line_d = raster_line_d;
   end

   assign clk_phi = phi;

endmodule

/* vicii_raster.f */
vic_pkg.sv
vic_timing.sv
vic_reg_decode.sv
vic_raster_irq.sv
vic_bus_arbiter.sv
vic_core.sv
tb_vic_core.sv
